/* logic/rv_pkg.sv */
// shared rv32i types and encodings; only word loads and stores exist, so no byte enables
`default_nettype none

package rv_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;

  // alu operation follows the funct3 meaning
  typedef logic [2:0] alu_op_t;

  localparam alu_op_t alu_add  = 3'b000;
  localparam alu_op_t alu_sll  = 3'b001;
  localparam alu_op_t alu_slt  = 3'b010;
  localparam alu_op_t alu_sltu = 3'b011;
  localparam alu_op_t alu_xor  = 3'b100;
  localparam alu_op_t alu_sr   = 3'b101;
  localparam alu_op_t alu_or   = 3'b110;
  localparam alu_op_t alu_and  = 3'b111;

  // register write-back source
  typedef logic [1:0] wb_src_t;

  localparam wb_src_t wb_alu = 2'b00;
  localparam wb_src_t wb_mem = 2'b01;
  localparam wb_src_t wb_pc4 = 2'b10;

  // major opcodes that the core accepts
  localparam opcode_t op_lui    = 7'b0110111;
  localparam opcode_t op_auipc  = 7'b0010111;
  localparam opcode_t op_jal    = 7'b1101111;
  localparam opcode_t op_jalr   = 7'b1100111;
  localparam opcode_t op_branch = 7'b1100011;
  localparam opcode_t op_load   = 7'b0000011;
  localparam opcode_t op_store  = 7'b0100011;
  localparam opcode_t op_imm    = 7'b0010011;
  localparam opcode_t op_reg    = 7'b0110011;
  localparam opcode_t op_system = 7'b1110011;

  typedef enum logic [3:0] {
    Idle,
    Fetch,
    Fetch_wait,
    Decode,
    Reg_reg,
    Reg_imm,
    Lui,
    Auipc,
    Jal,
    Jalr,
    Branch,
    Load,
    Load_wait,
    Store,
    Store_wait,
    Halt
  } core_state_e;

endpackage

`default_nettype wire

/* logic/ctrl_if.sv */
// decode fields and alu flags go to the control unit, strobes come back; no clock inside
`default_nettype none

interface ctrl_if;

  // from the instruction register and the alu
  rv_pkg::opcode_t opcode;
  rv_pkg::funct3_t funct3;
  logic            funct7_5;
  logic [11:0]     funct12;
  logic            rs2_is_zero;
  logic            zero;
  logic            negative;
  logic            carry_out;
  logic            overflow;

  // strobes from the fsm
  logic            alua_src;
  logic            alub_src;
  rv_pkg::alu_op_t alu_op;
  logic            sub;
  logic            arithmetic;
  logic            alupc_src;
  logic            pc_src;
  logic            pc_en;
  rv_pkg::wb_src_t wb_src;
  logic            reg_wr_en;
  logic            ir_en;
  logic            mem_addr_src;

  modport datapath (
    output opcode, funct3, funct7_5, funct12, rs2_is_zero,
    output zero, negative, carry_out, overflow,
    input  alua_src, alub_src, alu_op, sub, arithmetic, alupc_src,
    input  pc_src, pc_en, wb_src, reg_wr_en, ir_en, mem_addr_src
  );

  modport control (
    input  opcode, funct3, funct7_5, funct12, rs2_is_zero,
    input  zero, negative, carry_out, overflow,
    output alua_src, alub_src, alu_op, sub, arithmetic, alupc_src,
    output pc_src, pc_en, wb_src, reg_wr_en, ir_en, mem_addr_src
  );

endinterface

`default_nettype wire

/* logic/alu.sv */
// rv32i alu; flags always come from the adder, so sub must be set for compares
`default_nettype none

module alu (
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  input  rv_pkg::alu_op_t alu_op,
  input  logic            sub,
  input  logic            arithmetic,
  output rv_pkg::word_t   result,
  output logic            zero,
  output logic            negative,
  output logic            carry_out,
  output logic            overflow
);

  rv_pkg::word_t b_eff;
  rv_pkg::word_t shift_right;
  logic [32:0]   sum;

  // two's complement subtract through the same adder
  assign b_eff = sub ? ~b : b;
  assign sum   = {1'b0, a} + {1'b0, b_eff} + {32'b0, sub};

  assign zero      = (sum[31:0] == '0);
  assign negative  = sum[31];
  assign carry_out = sum[32];
  assign overflow  = (a[31] == b_eff[31]) && (sum[31] != a[31]);

  assign shift_right = arithmetic ? rv_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];

  always_comb begin
    case (alu_op)
      rv_pkg::alu_add:  result = sum[31:0];
      rv_pkg::alu_sll:  result = a << b[4:0];
      rv_pkg::alu_slt:  result = {31'b0, negative ^ overflow};
      // no carry out of a - b means a < b unsigned
      rv_pkg::alu_sltu: result = {31'b0, ~carry_out};
      rv_pkg::alu_xor:  result = a ^ b;
      rv_pkg::alu_sr:   result = shift_right;
      rv_pkg::alu_or:   result = a | b;
      default:          result = a & b;
    endcase
  end

endmodule

`default_nettype wire

/* logic/register_file.sv */
// 32 x 32 registers, x0 reads zero; a read in the write cycle returns the old value
`default_nettype none

module register_file (
  input  logic              clock,
  input  rv_pkg::reg_addr_t rs1_addr,
  input  rv_pkg::reg_addr_t rs2_addr,
  input  rv_pkg::reg_addr_t rd_addr,
  input  rv_pkg::word_t     rd_data,
  input  logic              wr_en,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data
);

  rv_pkg::word_t regs [32];

  always_ff @(posedge clock) begin
    if (wr_en && rd_addr != '0) regs[rd_addr] <= rd_data;
  end

  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

/* logic/imm_gen.sv */
// immediate by opcode; unknown opcodes fall back to the i format
`default_nettype none

module imm_gen (
  input  rv_pkg::word_t instr,
  output rv_pkg::word_t imm
);

  rv_pkg::opcode_t opcode;

  assign opcode = instr[6:0];

  always_comb begin
    case (opcode)
      rv_pkg::op_store:
        imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
      rv_pkg::op_branch:
        imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      rv_pkg::op_lui, rv_pkg::op_auipc:
        imm = {instr[31:12], 12'b0};
      rv_pkg::op_jal:
        imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      // loads, jalr, register-immediate
      default:
        imm = {{21{instr[31]}}, instr[30:20]};
    endcase
  end

endmodule

`default_nettype wire

/* logic/control_unit.sv */
// multicycle fsm; a request is held until busy has risen and fallen, ecall or illegal halts
`default_nettype none

module control_unit (
  input  logic    clock,
  input  logic    reset,
  input  logic    mem_busy,
  output logic    mem_rd_en,
  output logic    mem_wr_en,
  output logic    halted,
  output logic    illegal_instruction,
  ctrl_if.control cif
);

  rv_pkg::core_state_e state;
  rv_pkg::core_state_e next_state;
  logic illegal_q;
  logic illegal_now;
  logic branch_taken;
  logic slt_op;
  logic reg_legal;
  logic imm_legal;
  logic [6:0] funct7;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state     <= rv_pkg::Idle;
      illegal_q <= 1'b0;
    end else begin
      state <= next_state;
      if (illegal_now) illegal_q <= 1'b1;
    end
  end

  assign halted              = (state == rv_pkg::Halt);
  assign illegal_instruction = illegal_q;

  assign funct7 = cif.funct12[11:5];
  assign slt_op = (cif.funct3[2:1] == 2'b01);

  // only add/sub and srl/sra have a second funct7 encoding
  assign reg_legal = (funct7 == 7'b0000000) ||
                     (funct7 == 7'b0100000 &&
                      (cif.funct3 == 3'b000 || cif.funct3 == 3'b101));

  always_comb begin
    case (cif.funct3)
      3'b001:  imm_legal = (funct7 == 7'b0000000);
      3'b101:  imm_legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
      default: imm_legal = 1'b1;
    endcase
  end

  // flags come from rs1 - rs2
  always_comb begin
    case (cif.funct3[2:1])
      2'b00:   branch_taken = cif.zero ^ cif.funct3[0];
      2'b10:   branch_taken = (cif.negative ^ cif.overflow) ^ cif.funct3[0];
      2'b11:   branch_taken = ~cif.carry_out ^ cif.funct3[0];
      default: branch_taken = 1'b0;
    endcase
  end

  always_comb begin
    mem_rd_en        = 1'b0;
    mem_wr_en        = 1'b0;
    cif.alua_src     = 1'b0;
    cif.alub_src     = 1'b0;
    cif.alu_op       = rv_pkg::alu_add;
    cif.sub          = 1'b0;
    cif.arithmetic   = 1'b0;
    cif.alupc_src    = 1'b0;
    cif.pc_src       = 1'b0;
    cif.pc_en        = 1'b0;
    cif.wb_src       = rv_pkg::wb_alu;
    cif.reg_wr_en    = 1'b0;
    cif.ir_en        = 1'b0;
    cif.mem_addr_src = 1'b0;
    illegal_now      = 1'b0;
    next_state       = state;

    case (state)
      rv_pkg::Idle: next_state = rv_pkg::Fetch;

      rv_pkg::Fetch: begin
        mem_rd_en = 1'b1;
        if (mem_busy) next_state = rv_pkg::Fetch_wait;
      end

      rv_pkg::Fetch_wait: begin
        if (mem_busy) begin
          mem_rd_en = 1'b1;
        end else begin
          cif.ir_en  = 1'b1;
          next_state = rv_pkg::Decode;
        end
      end

      rv_pkg::Decode: begin
        // alu computes rs1 + imm here, registered as the load or store address
        cif.alub_src = 1'b1;
        if (cif.opcode[1:0] != 2'b11) begin
          illegal_now = 1'b1;
        end else begin
          case (cif.opcode)
            rv_pkg::op_reg:   if (reg_legal) next_state = rv_pkg::Reg_reg;
                              else illegal_now = 1'b1;
            rv_pkg::op_imm:   if (imm_legal) next_state = rv_pkg::Reg_imm;
                              else illegal_now = 1'b1;
            rv_pkg::op_lui:   next_state = rv_pkg::Lui;
            rv_pkg::op_auipc: next_state = rv_pkg::Auipc;
            rv_pkg::op_jal:   next_state = rv_pkg::Jal;
            rv_pkg::op_jalr:  if (cif.funct3 == 3'b000) next_state = rv_pkg::Jalr;
                              else illegal_now = 1'b1;
            rv_pkg::op_branch: if (cif.funct3[2:1] != 2'b01) next_state = rv_pkg::Branch;
                               else illegal_now = 1'b1;
            rv_pkg::op_load:  if (cif.funct3 == 3'b010) next_state = rv_pkg::Load;
                              else illegal_now = 1'b1;
            rv_pkg::op_store: if (cif.funct3 == 3'b010) next_state = rv_pkg::Store;
                              else illegal_now = 1'b1;
            rv_pkg::op_system: begin
              // ecall only, ebreak and csr accesses are illegal
              if (cif.funct3 == 3'b000 && funct7 == 7'b0000000 && cif.rs2_is_zero)
                next_state = rv_pkg::Halt;
              else
                illegal_now = 1'b1;
            end
            default: illegal_now = 1'b1;
          endcase
        end
        if (illegal_now) next_state = rv_pkg::Halt;
      end

      rv_pkg::Reg_reg: begin
        cif.alu_op     = cif.funct3;
        cif.sub        = (cif.funct7_5 && cif.funct3 == 3'b000) || slt_op;
        cif.arithmetic = cif.funct7_5;
        cif.pc_en      = 1'b1;
        cif.reg_wr_en  = 1'b1;
        next_state     = rv_pkg::Fetch;
      end

      rv_pkg::Reg_imm: begin
        cif.alub_src   = 1'b1;
        cif.alu_op     = cif.funct3;
        cif.sub        = slt_op;
        cif.arithmetic = cif.funct7_5 && (cif.funct3 == 3'b101);
        cif.pc_en      = 1'b1;
        cif.reg_wr_en  = 1'b1;
        next_state     = rv_pkg::Fetch;
      end

      // rs1 is forced to x0 for lui in the datapath
      rv_pkg::Lui: begin
        cif.alub_src  = 1'b1;
        cif.pc_en     = 1'b1;
        cif.reg_wr_en = 1'b1;
        next_state    = rv_pkg::Fetch;
      end

      rv_pkg::Auipc: begin
        cif.alua_src  = 1'b1;
        cif.alub_src  = 1'b1;
        cif.pc_en     = 1'b1;
        cif.reg_wr_en = 1'b1;
        next_state    = rv_pkg::Fetch;
      end

      rv_pkg::Jal: begin
        cif.pc_src    = 1'b1;
        cif.pc_en     = 1'b1;
        cif.wb_src    = rv_pkg::wb_pc4;
        cif.reg_wr_en = 1'b1;
        next_state    = rv_pkg::Fetch;
      end

      rv_pkg::Jalr: begin
        cif.alub_src  = 1'b1;
        cif.alupc_src = 1'b1;
        cif.pc_src    = 1'b1;
        cif.pc_en     = 1'b1;
        cif.wb_src    = rv_pkg::wb_pc4;
        cif.reg_wr_en = 1'b1;
        next_state    = rv_pkg::Fetch;
      end

      rv_pkg::Branch: begin
        cif.sub    = 1'b1;
        cif.pc_src = branch_taken;
        cif.pc_en  = 1'b1;
        next_state = rv_pkg::Fetch;
      end

      rv_pkg::Load, rv_pkg::Load_wait: begin
        cif.mem_addr_src = 1'b1;
        cif.alub_src     = 1'b1;
        cif.wb_src       = rv_pkg::wb_mem;
        if (state == rv_pkg::Load) begin
          mem_rd_en = 1'b1;
          if (mem_busy) next_state = rv_pkg::Load_wait;
        end else if (mem_busy) begin
          mem_rd_en = 1'b1;
        end else begin
          cif.pc_en     = 1'b1;
          cif.reg_wr_en = 1'b1;
          next_state    = rv_pkg::Fetch;
        end
      end

      rv_pkg::Store, rv_pkg::Store_wait: begin
        cif.mem_addr_src = 1'b1;
        cif.alub_src     = 1'b1;
        if (state == rv_pkg::Store) begin
          mem_wr_en = 1'b1;
          if (mem_busy) next_state = rv_pkg::Store_wait;
        end else if (mem_busy) begin
          mem_wr_en = 1'b1;
        end else begin
          cif.pc_en  = 1'b1;
          next_state = rv_pkg::Fetch;
        end
      end

      rv_pkg::Halt: next_state = rv_pkg::Halt;

      default: next_state = rv_pkg::Idle;
    endcase
  end

endmodule

`default_nettype wire

/* logic/datapath.sv */
// multicycle datapath; reset_pc must be word aligned, bus address and write data come from flops
`default_nettype none

module datapath #(
  parameter rv_pkg::word_t reset_pc = '0
) (
  input  logic          clock,
  input  logic          reset,
  ctrl_if.datapath      cif,
  output rv_pkg::word_t mem_addr,
  output rv_pkg::word_t mem_wdata,
  input  rv_pkg::word_t mem_rdata
);

  rv_pkg::word_t pc;
  rv_pkg::word_t pc_plus4;
  rv_pkg::word_t pc_next;
  rv_pkg::word_t branch_target;
  rv_pkg::word_t ir;
  rv_pkg::word_t imm;
  rv_pkg::word_t mdr;
  rv_pkg::word_t alu_out;
  rv_pkg::word_t alu_a;
  rv_pkg::word_t alu_b;
  rv_pkg::word_t alu_result;
  rv_pkg::word_t rs1_data;
  rv_pkg::word_t rs2_data;
  rv_pkg::word_t rd_data;
  rv_pkg::reg_addr_t rs1_addr;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) pc <= reset_pc;
    else if (cif.pc_en) pc <= pc_next;
  end

  // alu_out holds rs1 + imm from decode onward, mdr holds the store data
  always_ff @(posedge clock) begin
    if (cif.ir_en) ir <= mem_rdata;
    alu_out <= alu_result;
    mdr     <= rs2_data;
  end

  assign cif.opcode      = ir[6:0];
  assign cif.funct3      = ir[14:12];
  assign cif.funct7_5    = ir[30];
  assign cif.funct12     = ir[31:20];
  assign cif.rs2_is_zero = (ir[24:20] == '0);

  // lui has no rs1 field, read x0 so the alu adds zero
  assign rs1_addr = (ir[6:0] == rv_pkg::op_lui) ? '0 : ir[19:15];

  imm_gen u_imm_gen (
    .instr (ir),
    .imm   (imm)
  );

  register_file u_register_file (
    .clock    (clock),
    .rs1_addr (rs1_addr),
    .rs2_addr (ir[24:20]),
    .rd_addr  (ir[11:7]),
    .rd_data  (rd_data),
    .wr_en    (cif.reg_wr_en),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  assign alu_a = cif.alua_src ? pc : rs1_data;
  assign alu_b = cif.alub_src ? imm : rs2_data;

  alu u_alu (
    .a          (alu_a),
    .b          (alu_b),
    .alu_op     (cif.alu_op),
    .sub        (cif.sub),
    .arithmetic (cif.arithmetic),
    .result     (alu_result),
    .zero       (cif.zero),
    .negative   (cif.negative),
    .carry_out  (cif.carry_out),
    .overflow   (cif.overflow)
  );

  // separate adder leaves the alu for the branch compare
  assign branch_target = pc + imm;
  assign pc_plus4      = pc + 32'd4;

  always_comb begin
    if (!cif.pc_src) pc_next = pc_plus4;
    else if (cif.alupc_src) pc_next = {alu_result[31:1], 1'b0};
    else pc_next = branch_target;
  end

  always_comb begin
    case (cif.wb_src)
      rv_pkg::wb_mem: rd_data = mem_rdata;
      rv_pkg::wb_pc4: rd_data = pc_plus4;
      default:        rd_data = alu_result;
    endcase
  end

  assign mem_addr  = cif.mem_addr_src ? alu_out : pc;
  assign mem_wdata = mdr;

endmodule

`default_nettype wire

/* logic/rv_core.sv */
// rv32i core top; one word-wide memory port with a request/busy handshake, no interrupts
`default_nettype none

module rv_core #(
  parameter rv_pkg::word_t reset_pc = '0
) (
  input  logic          clock,
  input  logic          reset,
  output rv_pkg::word_t mem_addr,
  output rv_pkg::word_t mem_wdata,
  input  rv_pkg::word_t mem_rdata,
  output logic          mem_rd_en,
  output logic          mem_wr_en,
  input  logic          mem_busy,
  output logic          halted,
  output logic          illegal_instruction
);

  ctrl_if cif ();

  control_unit u_control_unit (
    .clock               (clock),
    .reset               (reset),
    .mem_busy            (mem_busy),
    .mem_rd_en           (mem_rd_en),
    .mem_wr_en           (mem_wr_en),
    .halted              (halted),
    .illegal_instruction (illegal_instruction),
    .cif                 (cif.control)
  );

  datapath #(
    .reset_pc (reset_pc)
  ) u_datapath (
    .clock     (clock),
    .reset     (reset),
    .cif       (cif.datapath),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata)
  );

endmodule

`default_nettype wire

/* dv/rv_core_props.sv */
// bound to rv_core; expects every request to see busy for at least one cycle
`default_nettype none

module rv_core_props (
  input logic          clock,
  input logic          reset,
  input rv_pkg::word_t mem_addr,
  input logic          mem_rd_en,
  input logic          mem_wr_en,
  input logic          mem_busy,
  input logic          halted
);
  timeunit 1ns;
  timeprecision 1ps;

  logic req;

  assign req = mem_rd_en || mem_wr_en;

  one_request: assert property (@(posedge clock) disable iff (reset)
    !(mem_rd_en && mem_wr_en)) else $error("read and write requested together");

  // request waits for busy to rise
  held_before_busy: assert property (@(posedge clock) disable iff (reset)
    req && !mem_busy |=> req && $stable(mem_addr) && $stable(mem_wr_en))
    else $error("request dropped before busy rose");

  held_while_busy: assert property (@(posedge clock) disable iff (reset)
    req && mem_busy ##1 mem_busy |-> req && $stable(mem_addr) && $stable(mem_rd_en))
    else $error("request changed while busy");

  fetch_aligned: assert property (@(posedge clock) disable iff (reset)
    mem_rd_en |-> mem_addr[1:0] == 2'b00) else $error("misaligned read address");

  halt_sticky: assert property (@(posedge clock) disable iff (reset)
    halted |=> halted) else $error("halted dropped without reset");

  halt_quiet: assert property (@(posedge clock) disable iff (reset)
    halted |-> !req) else $error("request made while halted");

endmodule

bind rv_core rv_core_props u_props (.*);

`default_nettype wire

/* dv/rv_core_tb.sv */
// programs sit at word 0 and must fit in 12 words; data words from 12 up hold a fill pattern
`default_nettype none

module rv_core_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int max_tests       = 40;
  localparam int prog_words      = 12;
  localparam int cycles_per_test = 200 * 12;
  localparam rv_pkg::word_t ecall = 32'h0000_0073;

  logic          clock = 1'b0;
  logic          reset;
  logic          mem_busy = 1'b0;
  rv_pkg::word_t mem_addr;
  rv_pkg::word_t mem_wdata;
  rv_pkg::word_t mem_rdata = '0;
  logic          mem_rd_en;
  logic          mem_wr_en;
  logic          halted;
  logic          illegal_instruction;

  rv_pkg::word_t mem [256];
  rv_pkg::word_t image [256];
  logic [2:0]    wait_left;

  string         test_name [max_tests];
  rv_pkg::word_t test_prog [max_tests][prog_words];
  rv_pkg::word_t test_addr [max_tests];
  rv_pkg::word_t test_exp [max_tests];
  logic          test_ill [max_tests];
  rv_pkg::word_t prog_buf [prog_words] = '{default: '0};
  int            num_tests = 0;
  int            errors = 0;
  int            passed = 0;
  logic          table_ready = 1'b0;
  string         current = "none";

  rv_core DUT (.*);

  always #5 clock = ~clock;

  // word memory stays busy for 1 to 4 cycles per request and answers as busy falls
  always @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 256; i++) mem[i] <= image[i];
      mem_busy  <= 1'b0;
      wait_left <= 3'd0;
    end else if (mem_busy) begin
      if (wait_left == 3'd1) begin
        mem_busy <= 1'b0;
        if (mem_wr_en) mem[mem_addr[9:2]] <= mem_wdata;
        if (mem_rd_en) mem_rdata <= mem[mem_addr[9:2]];
      end else begin
        wait_left <= wait_left - 3'd1;
      end
    end else if (mem_rd_en || mem_wr_en) begin
      mem_busy  <= 1'b1;
      wait_left <= 3'($urandom_range(4, 1));
    end
  end

  function automatic rv_pkg::word_t fill(input int index);
    return rv_pkg::word_t'(index * 4) * 32'h9e37_79b9 ^ 32'hc3a5_0f1e;
  endfunction

  // x3 = x1 op x2
  function automatic rv_pkg::word_t r_op(input logic [6:0] f7, input logic [2:0] f3);
    return {f7, 5'd2, 5'd1, f3, 5'd3, 7'b0110011};
  endfunction

  // x3 = x1 op imm
  function automatic rv_pkg::word_t i_op(input logic [11:0] imm, input logic [2:0] f3);
    return {imm, 5'd1, f3, 5'd3, 7'b0010011};
  endfunction

  function automatic rv_pkg::word_t addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic rv_pkg::word_t sw(input logic [4:0] rs2, input logic [11:0] imm);
    return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  // compares x1 with x2
  function automatic rv_pkg::word_t branch(input logic [2:0] f3, input logic [12:0] imm);
    return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic rv_pkg::word_t jal(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic add_test(input string name, input rv_pkg::word_t addr,
                          input rv_pkg::word_t exp, input logic ill);
    test_name[num_tests] = name;
    for (int i = 0; i < prog_words; i++) begin
      test_prog[num_tests][i] = prog_buf[i];
      prog_buf[i] = '0;
    end
    test_addr[num_tests] = addr;
    test_exp[num_tests]  = exp;
    test_ill[num_tests]  = ill;
    num_tests++;
  endtask

  // x1 = -7, x2 = 3, result in x3 stored at 0x200
  task automatic alu_case(input string name, input rv_pkg::word_t instr,
                          input rv_pkg::word_t exp);
    prog_buf[0] = addi(5'd1, 5'd0, 12'hff9);
    prog_buf[1] = addi(5'd2, 5'd0, 12'h003);
    prog_buf[2] = instr;
    prog_buf[3] = sw(5'd3, 12'h200);
    prog_buf[4] = ecall;
    add_test(name, 32'h200, exp, 1'b0);
  endtask

  // taken path stores 0x22, fall-through stores 0x11
  task automatic branch_case(input string name, input logic [2:0] f3, input logic [11:0] a,
                             input logic [11:0] b, input logic taken);
    prog_buf[0] = addi(5'd1, 5'd0, a);
    prog_buf[1] = addi(5'd2, 5'd0, b);
    prog_buf[2] = branch(f3, 13'd12);
    prog_buf[3] = addi(5'd3, 5'd0, 12'h011);
    prog_buf[4] = jal(5'd0, 21'd8);
    prog_buf[5] = addi(5'd3, 5'd0, 12'h022);
    prog_buf[6] = sw(5'd3, 12'h200);
    prog_buf[7] = ecall;
    add_test(name, 32'h200, taken ? 32'h22 : 32'h11, 1'b0);
  endtask

  task automatic build_table();
    alu_case("add", r_op(7'h00, 3'b000), 32'hffff_fffc);
    alu_case("sub", r_op(7'h20, 3'b000), 32'hffff_fff6);
    alu_case("sll", r_op(7'h00, 3'b001), 32'hffff_ffc8);
    alu_case("slt", r_op(7'h00, 3'b010), 32'h0000_0001);
    alu_case("sltu", r_op(7'h00, 3'b011), 32'h0000_0000);
    alu_case("xor", r_op(7'h00, 3'b100), 32'hffff_fffa);
    alu_case("srl", r_op(7'h00, 3'b101), 32'h1fff_ffff);
    alu_case("sra", r_op(7'h20, 3'b101), 32'hffff_ffff);
    alu_case("or", r_op(7'h00, 3'b110), 32'hffff_fffb);
    alu_case("and", r_op(7'h00, 3'b111), 32'h0000_0001);
    alu_case("addi", i_op(12'hf9c, 3'b000), 32'hffff_ff95);
    alu_case("slti", i_op(12'hff8, 3'b010), 32'h0000_0000);
    alu_case("sltiu", i_op(12'hfff, 3'b011), 32'h0000_0001);
    alu_case("xori", i_op(12'h0f0, 3'b100), 32'hffff_ff09);
    alu_case("slli", i_op(12'h004, 3'b001), 32'hffff_ff90);
    alu_case("srai", i_op(12'h401, 3'b101), 32'hffff_fffc);
    alu_case("lui", {20'h12345, 5'd3, 7'b0110111}, 32'h1234_5000);
    // auipc sits at address 8
    alu_case("auipc", {20'h00001, 5'd3, 7'b0010111}, 32'h0000_1008);
    branch_case("beq_t", 3'b000, 12'h003, 12'h003, 1'b1);
    branch_case("beq_n", 3'b000, 12'hff9, 12'h003, 1'b0);
    branch_case("bne_t", 3'b001, 12'hff9, 12'h003, 1'b1);
    branch_case("bne_n", 3'b001, 12'h003, 12'h003, 1'b0);
    branch_case("blt_t", 3'b100, 12'hff9, 12'h003, 1'b1);
    branch_case("blt_n", 3'b100, 12'h003, 12'hff9, 1'b0);
    branch_case("bge_t", 3'b101, 12'h003, 12'hff9, 1'b1);
    branch_case("bge_n", 3'b101, 12'hff9, 12'h003, 1'b0);
    branch_case("bltu_t", 3'b110, 12'h003, 12'hff9, 1'b1);
    branch_case("bltu_n", 3'b110, 12'hff9, 12'h003, 1'b0);
    branch_case("bgeu_t", 3'b111, 12'hff9, 12'h003, 1'b1);
    branch_case("bgeu_n", 3'b111, 12'h003, 12'hff9, 1'b0);
    // jal links x1 = 4 and jalr links x2 = 20 on its way to 25 & ~1
    prog_buf[0] = jal(5'd1, 21'd12);
    prog_buf[1] = addi(5'd3, 5'd0, 12'h055);
    prog_buf[2] = ecall;
    prog_buf[3] = addi(5'd5, 5'd0, 12'd25);
    prog_buf[4] = {12'h000, 5'd5, 3'b000, 5'd2, 7'b1100111};
    prog_buf[5] = ecall;
    // auipc at the jalr target gives x4 = 24 only with bit 0 cleared
    prog_buf[6] = {20'h00000, 5'd4, 7'b0010111};
    prog_buf[7] = {7'h00, 5'd8, 5'd2, 3'b001, 5'd2, 7'b0010011};
    prog_buf[8] = r_op(7'h00, 3'b000);
    prog_buf[9] = {7'h00, 5'd4, 5'd3, 3'b000, 5'd3, 7'b0110011};
    prog_buf[10] = sw(5'd3, 12'h200);
    prog_buf[11] = ecall;
    add_test("jal_jalr", 32'h200, 32'h0000_141c, 1'b0);
    prog_buf[0] = {20'hdeadb, 5'd1, 7'b0110111};
    prog_buf[1] = addi(5'd1, 5'd1, 12'heef);
    prog_buf[2] = sw(5'd1, 12'h200);
    prog_buf[3] = {12'h200, 5'd0, 3'b010, 5'd2, 7'b0000011};
    prog_buf[4] = addi(5'd2, 5'd2, 12'h001);
    prog_buf[5] = sw(5'd2, 12'h200);
    prog_buf[6] = ecall;
    add_test("sw_lw", 32'h200, 32'hdead_aef0, 1'b0);
    prog_buf[0] = addi(5'd1, 5'd0, 12'h005);
    prog_buf[1] = {12'h200, 5'd0, 3'b000, 5'd3, 7'b0000011};
    prog_buf[2] = sw(5'd1, 12'h200);
    prog_buf[3] = ecall;
    add_test("lb_illegal", 32'h200, fill(128), 1'b1);
    prog_buf[0] = addi(5'd1, 5'd0, 12'h005);
    prog_buf[1] = {12'h300, 5'd1, 3'b001, 5'd3, 7'b1110011};
    prog_buf[2] = sw(5'd1, 12'h200);
    prog_buf[3] = ecall;
    add_test("csr_illegal", 32'h200, fill(128), 1'b1);
  endtask

  task automatic check_word(input string what, input rv_pkg::word_t exp,
                            input rv_pkg::word_t act);
    if (act !== exp) begin
      $display("FAILED %s expected %h actual %h", what, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED %s expected %b actual %b", what, exp, act);
      errors++;
    end
  endtask

  initial begin
    int start;
    int check_index;
    reset = 1'b1;
    void'($urandom(32'hbfc9_16c4));
    build_table();
    table_ready = 1'b1;
    for (int t = 0; t < num_tests; t++) begin
      current = test_name[t];
      for (int i = 0; i < 256; i++) image[i] = (i < prog_words) ? test_prog[t][i] : fill(i);
      @(posedge clock);
      reset <= 1'b1;
      repeat (2) @(posedge clock);
      reset <= 1'b0;
      @(posedge clock);
      while (!halted) @(posedge clock);
      @(posedge clock);
      start = errors;
      check_index = int'(test_addr[t][9:2]);
      check_word(current, test_exp[t], mem[check_index]);
      check_bit({current, " illegal"}, test_ill[t], illegal_instruction);
      // everything else in the data area keeps its fill value
      for (int i = prog_words; i < 256; i++) begin
        if (i != check_index) check_word($sformatf("%s @%h", current, i * 4), fill(i), mem[i]);
      end
      if (errors == start) begin
        passed++;
        $display("test %s ok", current);
      end else begin
        $display("test %s had %0d mismatches", current, errors - start);
      end
    end
    $display("tests %0d, passed %0d, mismatches %0d", num_tests, passed, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    wait (table_ready);
    #(cycles_per_test * num_tests * 10);
    $display("timeout, test %s never reached halt", current);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
logic/rv_pkg.sv
logic/ctrl_if.sv
logic/alu.sv
logic/register_file.sv
logic/imm_gen.sv
logic/control_unit.sv
logic/datapath.sv
logic/rv_core.sv
dv/rv_core_props.sv
dv/rv_core_tb.sv

/* run.sh */
#!/bin/sh
# build and run the rv_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module rv_core_tb -f filelist.f \
  || { echo "build failed"; exit 1; }
./obj_dir/Vrv_core_tb > sim.log 2>&1
cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && { echo "simulation reported failure"; exit 1; }
grep -q '\*\* PASS \*\*' sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"
